// File: design/int_issue_pkg.sv
package int_issue_pkg;

    // ================================================
    // Unit timing
    // ================================================

    // Cycles each unit adds after the issue register
    localparam int ALU_LATENCY = 0;
    localparam int BMU_LATENCY = 1;
    localparam int MUL_LATENCY = 4;
    localparam int DIV_LATENCY = 34;

    // Load/store occupancy from issue to writeback
    localparam int LSU_BUSY_CYCLES = 3;

    // Queue entries, equal to the dispatcher's credits after reset
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

    // Scheduler tracker layout
    // MUL slots first, then BMU slots, DIV slot last
    localparam int TRACK_SLOTS = MUL_LATENCY + BMU_LATENCY + 1;
    localparam int DIV_SLOT = TRACK_SLOTS - 1;

    // ================================================
    // Types
    // ================================================

    typedef logic [4:0] reg_addr_t;
    typedef logic [7:0] instr_tag_t;
    typedef logic [5:0] lat_cnt_t;
    typedef logic [2:0] credit_cnt_t;

    typedef enum logic [2:0] {
        UNIT_ALU,
        UNIT_BMU,
        UNIT_MUL,
        UNIT_DIV,
        UNIT_LOAD,
        UNIT_STORE
    } exec_unit_e;

    // Decoded instruction as seen by the issue stage
    typedef struct packed {
        exec_unit_e unit;
        reg_addr_t  src1;
        reg_addr_t  src2;
        reg_addr_t  dest;
        instr_tag_t tag;
    } issue_instr_t;

    // One result on a writeback port
    typedef struct packed {
        logic       valid;
        reg_addr_t  dest;
        instr_tag_t tag;
    } writeback_t;

endpackage

// File: design/issue_queue.sv
`timescale 1ns/1ps

module issue_queue (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        kill_i,
    input  logic                        dispatch_valid_i,
    input  int_issue_pkg::issue_instr_t dispatch_instr_i,
    input  logic                        issue_i,
    output logic                        head_valid_o,
    output int_issue_pkg::issue_instr_t head_instr_o,
    output logic                        credit_return_o
);
    import int_issue_pkg::*;

    issue_instr_t             mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0]   wr_ptr;
    logic [QUEUE_PTR_W-1:0]   rd_ptr;
    credit_cnt_t              count;
    credit_cnt_t              flush_cnt;
    credit_cnt_t              kill_credits;
    logic                     push;
    logic                     drain;

    // A dispatch in the kill cycle is dropped and its credit is flushed
    assign push = dispatch_valid_i && !kill_i;

    // Issue owns the credit pulse, flush credits wait for a free cycle
    assign drain = !issue_i && (flush_cnt != '0);
    assign credit_return_o = issue_i || (flush_cnt != '0);

    // Entries that leave without issue on a kill
    assign kill_credits = kill_i ?
        count + credit_cnt_t'(dispatch_valid_i) - credit_cnt_t'(issue_i) : '0;

    assign head_valid_o = (count != '0);
    assign head_instr_o = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            flush_cnt <= '0;
        end else begin
            flush_cnt <= flush_cnt + kill_credits - credit_cnt_t'(drain);
            if (kill_i) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                // Pointers wrap on their own, depth is a power of two
                wr_ptr <= wr_ptr + QUEUE_PTR_W'(push);
                rd_ptr <= rd_ptr + QUEUE_PTR_W'(issue_i);
                count  <= count + credit_cnt_t'(push) - credit_cnt_t'(issue_i);
            end
        end
    end

    // Storage only
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= dispatch_instr_i;
        end
    end

    // A credit freed by issue reaches the dispatcher only after this cycle
    a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dispatch_valid_i |-> (count != credit_cnt_t'(QUEUE_DEPTH)));

    // Scheduler never issues from an empty queue
    a_no_issue_empty : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        issue_i |-> head_valid_o);

endmodule

// File: design/int_scheduler.sv
`timescale 1ns/1ps

module int_scheduler (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        kill_i,
    input  logic                        head_valid_i,
    input  int_issue_pkg::issue_instr_t head_instr_i,
    input  logic                        lsu_idle_i,
    output logic                        issue_o,
    output logic                        pipeline_empty_o
);
    import int_issue_pkg::*;

    lat_cnt_t               slot_cnt  [TRACK_SLOTS];
    reg_addr_t              slot_dest [TRACK_SLOTS];
    logic [TRACK_SLOTS-1:0] slot_live;
    logic [TRACK_SLOTS-1:0] slot_load;
    logic [TRACK_SLOTS-1:0] slot_raw;
    logic [TRACK_SLOTS-1:0] slot_lat;
    logic [TRACK_SLOTS-1:0] slot_ending;
    lat_cnt_t               mul_ptr;
    lat_cnt_t               bmu_ptr;
    lat_cnt_t               head_latency;
    reg_addr_t              ld_dest;
    reg_addr_t              st_dest;
    logic                   issue_mul;
    logic                   issue_bmu;
    logic                   issue_div;
    logic                   issue_ld;
    logic                   issue_st;
    logic                   unit_busy;
    logic                   raw_hazard;
    logic                   latency_hazard;

    // Nonzero register shared with any operand of the head
    function automatic logic hits(input reg_addr_t r, input issue_instr_t h);
        return (r != '0) && ((r == h.src1) || (r == h.src2) || (r == h.dest));
    endfunction

    // Countdown loaded into a slot on issue
    function automatic lat_cnt_t slot_init(input int idx);
        if (idx < MUL_LATENCY) begin
            return lat_cnt_t'(MUL_LATENCY);
        end else if (idx < DIV_SLOT) begin
            return lat_cnt_t'(BMU_LATENCY);
        end
        return lat_cnt_t'(DIV_LATENCY);
    endfunction

    // ================================================
    // Head latency and issue strobes
    // ================================================

    always_comb begin
        case (head_instr_i.unit)
            UNIT_ALU: head_latency = lat_cnt_t'(ALU_LATENCY + 1);
            UNIT_BMU: head_latency = lat_cnt_t'(BMU_LATENCY + 1);
            UNIT_MUL: head_latency = lat_cnt_t'(MUL_LATENCY + 1);
            UNIT_DIV: head_latency = lat_cnt_t'(DIV_LATENCY + 1);
            // LSU results use their own port
            default:  head_latency = '0;
        endcase
    end

    assign issue_mul = issue_o && (head_instr_i.unit == UNIT_MUL);
    assign issue_bmu = issue_o && (head_instr_i.unit == UNIT_BMU);
    assign issue_div = issue_o && (head_instr_i.unit == UNIT_DIV);
    assign issue_ld  = issue_o && (head_instr_i.unit == UNIT_LOAD);
    assign issue_st  = issue_o && (head_instr_i.unit == UNIT_STORE);

    // Round-robin slot pick inside each unit's group
    always_comb begin
        for (int i = 0; i < TRACK_SLOTS; i++) begin
            if (i < MUL_LATENCY) begin
                slot_load[i] = issue_mul && (mul_ptr == lat_cnt_t'(i));
            end else if (i < DIV_SLOT) begin
                slot_load[i] = issue_bmu && (bmu_ptr == lat_cnt_t'(i - MUL_LATENCY));
            end else begin
                slot_load[i] = issue_div;
            end
        end
    end

    // ================================================
    // In-flight trackers
    // ================================================

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < TRACK_SLOTS; i++) begin
            if (!rst_n_i || kill_i) begin
                slot_cnt[i] <= '0;
            end else if (slot_load[i]) begin
                slot_cnt[i] <= slot_init(i);
            end else if (slot_live[i]) begin
                slot_cnt[i] <= slot_cnt[i] - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || kill_i) begin
            mul_ptr <= '0;
            bmu_ptr <= '0;
        end else begin
            if (issue_mul) begin
                mul_ptr <= (mul_ptr == lat_cnt_t'(MUL_LATENCY - 1)) ? '0 : mul_ptr + 1'b1;
            end
            if (issue_bmu) begin
                bmu_ptr <= (bmu_ptr == lat_cnt_t'(BMU_LATENCY - 1)) ? '0 : bmu_ptr + 1'b1;
            end
        end
    end

    // Destinations only matter while the matching slot or the LSU is busy
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < TRACK_SLOTS; i++) begin
            if (slot_load[i]) begin
                slot_dest[i] <= head_instr_i.dest;
            end
        end
        if (issue_ld) begin
            ld_dest <= head_instr_i.dest;
            st_dest <= '0;
        end else if (issue_st) begin
            st_dest <= head_instr_i.dest;
            ld_dest <= '0;
        end
    end

    // ================================================
    // Hazards and issue
    // ================================================

    always_comb begin
        for (int i = 0; i < TRACK_SLOTS; i++) begin
            slot_live[i]   = (slot_cnt[i] != '0);
            slot_ending[i] = (slot_cnt[i] == lat_cnt_t'(1));
            slot_raw[i]    = slot_live[i] && hits(slot_dest[i], head_instr_i);
            // Head would share the writeback cycle with this slot
            slot_lat[i]    = slot_live[i] && (slot_cnt[i] == head_latency);
        end
    end

    assign raw_hazard = (|slot_raw) || (!lsu_idle_i &&
        (hits(ld_dest, head_instr_i) || hits(st_dest, head_instr_i)));
    assign latency_hazard = |slot_lat;

    // DIV and LSU are not pipelined
    assign unit_busy = ((head_instr_i.unit == UNIT_DIV) && slot_live[DIV_SLOT]) ||
        (((head_instr_i.unit == UNIT_LOAD) || (head_instr_i.unit == UNIT_STORE)) &&
        !lsu_idle_i);

    // Head in a kill cycle is flushed, not issued
    assign issue_o = head_valid_i && !kill_i && !(raw_hazard || latency_hazard || unit_busy);

    assign pipeline_empty_o = !(|slot_live) && lsu_idle_i;

    // One tracked result per writeback cycle
    a_single_ending : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(slot_ending));

endmodule

// File: design/int_exec_units.sv
`timescale 1ns/1ps

module int_exec_units (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        kill_i,
    input  logic                        issue_i,
    input  int_issue_pkg::issue_instr_t instr_i,
    output int_issue_pkg::writeback_t   int_wb_o
);
    import int_issue_pkg::*;

    writeback_t alu_pipe [ALU_LATENCY + 1];
    writeback_t bmu_pipe [BMU_LATENCY + 1];
    writeback_t mul_pipe [MUL_LATENCY + 1];
    writeback_t div_entry;
    lat_cnt_t   div_cnt;
    writeback_t alu_out;
    writeback_t bmu_out;
    writeback_t mul_out;
    logic       alu_sel;
    logic       bmu_sel;
    logic       mul_sel;
    logic       div_sel;
    logic       div_done;

    assign alu_sel = issue_i && (instr_i.unit == UNIT_ALU);
    assign bmu_sel = issue_i && (instr_i.unit == UNIT_BMU);
    assign mul_sel = issue_i && (instr_i.unit == UNIT_MUL);
    assign div_sel = issue_i && (instr_i.unit == UNIT_DIV);

    // ================================================
    // Pipelined units
    // ================================================

    // Stage 0 is the issue register, last stage feeds writeback
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || kill_i) begin
            alu_pipe <= '{default: '0};
            bmu_pipe <= '{default: '0};
            mul_pipe <= '{default: '0};
        end else begin
            alu_pipe[0] <= '{valid: alu_sel, dest: instr_i.dest, tag: instr_i.tag};
            bmu_pipe[0] <= '{valid: bmu_sel, dest: instr_i.dest, tag: instr_i.tag};
            mul_pipe[0] <= '{valid: mul_sel, dest: instr_i.dest, tag: instr_i.tag};
            for (int s = 1; s <= ALU_LATENCY; s++) begin
                alu_pipe[s] <= alu_pipe[s-1];
            end
            for (int s = 1; s <= BMU_LATENCY; s++) begin
                bmu_pipe[s] <= bmu_pipe[s-1];
            end
            for (int s = 1; s <= MUL_LATENCY; s++) begin
                mul_pipe[s] <= mul_pipe[s-1];
            end
        end
    end

    assign alu_out = alu_pipe[ALU_LATENCY];
    assign bmu_out = bmu_pipe[BMU_LATENCY];
    assign mul_out = mul_pipe[MUL_LATENCY];

    // ================================================
    // Divider
    // ================================================

    // Single entry, counts down to its writeback cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || kill_i) begin
            div_entry <= '0;
            div_cnt   <= '0;
        end else if (div_sel) begin
            div_entry <= '{valid: 1'b1, dest: instr_i.dest, tag: instr_i.tag};
            div_cnt   <= lat_cnt_t'(DIV_LATENCY);
        end else if (div_done) begin
            div_entry.valid <= 1'b0;
        end else if (div_entry.valid) begin
            div_cnt <= div_cnt - 1'b1;
        end
    end

    assign div_done = div_entry.valid && (div_cnt == '0);

    // ================================================
    // Writeback merge
    // ================================================

    always_comb begin
        int_wb_o = '0;
        if (alu_out.valid) begin
            int_wb_o = alu_out;
        end else if (bmu_out.valid) begin
            int_wb_o = bmu_out;
        end else if (mul_out.valid) begin
            int_wb_o = mul_out;
        end else if (div_done) begin
            int_wb_o = div_entry;
        end
    end

    // Scheduler latency checks keep the shared port collision free
    a_one_writeback : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({alu_out.valid, bmu_out.valid, mul_out.valid, div_done}));

endmodule

// File: design/lsu_model.sv
`timescale 1ns/1ps

module lsu_model (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        kill_i,
    input  logic                        issue_i,
    input  int_issue_pkg::issue_instr_t instr_i,
    output logic                        lsu_idle_o,
    output int_issue_pkg::writeback_t   lsu_wb_o
);
    import int_issue_pkg::*;

    logic       busy;
    lat_cnt_t   busy_cnt;
    writeback_t entry;
    logic       done;

    // Busy from the cycle after issue through the writeback cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || kill_i) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (issue_i) begin
            busy     <= 1'b1;
            busy_cnt <= lat_cnt_t'(LSU_BUSY_CYCLES - 1);
        end else if (done) begin
            busy <= 1'b0;
        end else if (busy) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    // Valid bit marks a load, stores only occupy the unit
    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            entry <= '{valid: instr_i.unit == UNIT_LOAD, dest: instr_i.dest, tag: instr_i.tag};
        end
    end

    assign done = busy && (busy_cnt == '0);
    assign lsu_idle_o = !busy;
    assign lsu_wb_o = '{valid: done && entry.valid, dest: entry.dest, tag: entry.tag};

    // Scheduler holds LSU heads until the unit is free
    a_issue_idle : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        issue_i |-> lsu_idle_o);

endmodule

// File: design/int_issue_top.sv
`timescale 1ns/1ps

module int_issue_top (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        kill_i,
    input  logic                        dispatch_valid_i,
    input  int_issue_pkg::issue_instr_t dispatch_instr_i,
    output logic                        credit_return_o,
    output int_issue_pkg::writeback_t   int_wb_o,
    output int_issue_pkg::writeback_t   lsu_wb_o,
    output logic                        pipeline_empty_o
);
    import int_issue_pkg::*;

    logic         head_valid;
    issue_instr_t head_instr;
    logic         issue;
    logic         lsu_idle;
    logic         lsu_issue;
    logic         int_issue;

    // Issue goes to the unit group named by the head
    assign lsu_issue = issue &&
        ((head_instr.unit == UNIT_LOAD) || (head_instr.unit == UNIT_STORE));
    assign int_issue = issue && !lsu_issue;

    issue_queue u_queue (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .kill_i           (kill_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_instr_i (dispatch_instr_i),
        .issue_i          (issue),
        .head_valid_o     (head_valid),
        .head_instr_o     (head_instr),
        .credit_return_o  (credit_return_o)
    );

    int_scheduler u_sched (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .kill_i           (kill_i),
        .head_valid_i     (head_valid),
        .head_instr_i     (head_instr),
        .lsu_idle_i       (lsu_idle),
        .issue_o          (issue),
        .pipeline_empty_o (pipeline_empty_o)
    );

    int_exec_units u_units (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .kill_i   (kill_i),
        .issue_i  (int_issue),
        .instr_i  (head_instr),
        .int_wb_o (int_wb_o)
    );

    lsu_model u_lsu (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .kill_i     (kill_i),
        .issue_i    (lsu_issue),
        .instr_i    (head_instr),
        .lsu_idle_o (lsu_idle),
        .lsu_wb_o   (lsu_wb_o)
    );

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);
    // 40 ns period
    localparam time HALF_PERIOD = 20ns;
    localparam int  RESET_CYCLES = 10;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// File: tests/tb_int_issue.sv
`timescale 1ns/1ps

module tb_int_issue;
    import int_issue_pkg::*;

    localparam int WAIT_LIMIT = 500;
    localparam int FILL_ROWS = 40;

    // One stimulus row, kill is applied before the row is sent
    typedef struct packed {
        logic       kill;
        exec_unit_e unit;
        reg_addr_t  src1;
        reg_addr_t  src2;
        reg_addr_t  dest;
    } row_t;

    logic         clk;
    logic         rst_n;
    logic         kill;
    logic         dispatch_valid;
    issue_instr_t dispatch_instr;
    logic         credit_return;
    writeback_t   int_wb;
    writeback_t   lsu_wb;
    logic         pipeline_empty;

    // Scoreboard, indexed by tag
    row_t        rows [$];
    exec_unit_e  exp_unit [256];
    reg_addr_t   exp_dest [256];
    bit          pending [256];
    bit          killed [256];
    int          wb_cycle [256];
    int          dep_tag [256][3];
    int          last_writer [32];
    int          credits;
    int          outstanding;
    int          cycle;
    int          checks;
    int          errors;
    int          timeouts;
    int          div_tag;
    int          alu_tag;
    logic [31:0] seed;

    tb_clock_gen u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    int_issue_top DUT (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .kill_i           (kill),
        .dispatch_valid_i (dispatch_valid),
        .dispatch_instr_i (dispatch_instr),
        .credit_return_o  (credit_return),
        .int_wb_o         (int_wb),
        .lsu_wb_o         (lsu_wb),
        .pipeline_empty_o (pipeline_empty)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_eq(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    function automatic void add_row(input logic k, input exec_unit_e u,
                                    input reg_addr_t s1, input reg_addr_t s2,
                                    input reg_addr_t d);
        rows.push_back(row_t'{kill: k, unit: u, src1: s1, src2: s2, dest: d});
    endfunction

    // ================================================
    // Stimulus table
    // ================================================

    task automatic build_rows();
        logic       k;
        exec_unit_e u;
        reg_addr_t  d;
        // MUL then dependent ALU
        add_row(1'b0, UNIT_MUL, 5'd1, 5'd2, 5'd5);
        add_row(1'b0, UNIT_ALU, 5'd5, 5'd0, 5'd13);
        // Long DIV with an independent ALU behind it
        div_tag = rows.size() + 1;
        add_row(1'b0, UNIT_DIV, 5'd3, 5'd4, 5'd6);
        alu_tag = rows.size() + 1;
        add_row(1'b0, UNIT_ALU, 5'd1, 5'd2, 5'd7);
        // DIV then dependent load, then load-use
        add_row(1'b0, UNIT_LOAD, 5'd6, 5'd0, 5'd8);
        add_row(1'b0, UNIT_ALU, 5'd8, 5'd0, 5'd9);
        add_row(1'b0, UNIT_STORE, 5'd9, 5'd8, 5'd0);
        add_row(1'b0, UNIT_BMU, 5'd9, 5'd1, 5'd10);
        // Work in flight when the kill lands
        add_row(1'b0, UNIT_DIV, 5'd10, 5'd2, 5'd11);
        add_row(1'b0, UNIT_MUL, 5'd3, 5'd4, 5'd12);
        add_row(1'b0, UNIT_ALU, 5'd11, 5'd0, 5'd13);
        add_row(1'b1, UNIT_ALU, 5'd1, 5'd0, 5'd14);
        // Filler, small register range so hazards are common
        seed = 32'hfc7a;
        for (int i = 0; i < FILL_ROWS; i++) begin
            seed = lcg_next(seed);
            u = exec_unit_e'(3'(seed[31:24] % 8'd6));
            d = (u == UNIT_STORE) ? '0 : reg_addr_t'(seed[15:13]);
            k = (i == FILL_ROWS / 2);
            add_row(k, u, reg_addr_t'(seed[18:16]), reg_addr_t'(seed[21:19]), d);
        end
    endtask

    // ================================================
    // Dispatcher model
    // ================================================

    task automatic send_row(input int idx);
        row_t      r;
        int        t;
        reg_addr_t regs [3];
        r = rows[idx];
        t = idx + 1;
        regs[0] = r.src1;
        regs[1] = r.src2;
        regs[2] = r.dest;
        // Latest producer of each register that is still outstanding
        for (int k = 0; k < 3; k++) begin
            dep_tag[t][k] = -1;
            if (regs[k] != '0 && last_writer[regs[k]] >= 0) begin
                if (pending[last_writer[regs[k]]]) begin
                    dep_tag[t][k] = last_writer[regs[k]];
                end
            end
        end
        exp_unit[t] = r.unit;
        exp_dest[t] = r.dest;
        if (r.unit != UNIT_STORE) begin
            pending[t] = 1'b1;
            outstanding++;
            if (r.dest != '0) begin
                last_writer[r.dest] = t;
            end
        end
        dispatch_instr = '{unit: r.unit, src1: r.src1, src2: r.src2, dest: r.dest,
                           tag: instr_tag_t'(t)};
        dispatch_valid = 1'b1;
        credits--;
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    task automatic wait_credit();
        int n;
        n = 0;
        while (credits == 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (credits == 0) begin
            timeouts++;
            $display("Timed out waiting for a dispatch credit");
        end
    endtask

    // All results seen, units quiet, no credit pulse still running
    task automatic wait_idle(input string what);
        int n;
        n = 0;
        while (!(outstanding == 0 && pipeline_empty && !credit_return) &&
               n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            timeouts++;
            $display("Timed out waiting for %s", what);
        end
    endtask

    task automatic apply_kill();
        kill = 1'b1;
        @(negedge clk);
        kill = 1'b0;
        wait_idle("the pipeline to empty after a kill");
        check_eq("credits_after_kill", credits, QUEUE_DEPTH);
    endtask

    // ================================================
    // Writeback monitor
    // ================================================

    task automatic take_writeback(input writeback_t wb, input bit on_lsu);
        int t;
        int d;
        t = int'(wb.tag);
        if (killed[t]) begin
            errors++;
            $display("Tag %0d was killed but still wrote back at %0t", t, $time);
        end else if (!pending[t]) begin
            errors++;
            $display("Tag %0d wrote back with no outstanding instruction at %0t", t, $time);
        end else begin
            check_eq($sformatf("tag%0d_lsu_port", t), int'(on_lsu),
                     int'(exp_unit[t] == UNIT_LOAD));
            check_eq($sformatf("tag%0d_dest", t), int'(wb.dest), int'(exp_dest[t]));
            for (int k = 0; k < 3; k++) begin
                d = dep_tag[t][k];
                if (d >= 0) begin
                    check_eq($sformatf("tag%0d_after_tag%0d", t, d),
                             int'(wb_cycle[d] >= 0 && wb_cycle[d] < cycle), 1);
                end
            end
            pending[t] = 1'b0;
            wb_cycle[t] = cycle;
            outstanding--;
        end
    endtask

    task automatic flush_outstanding();
        for (int t = 0; t < 256; t++) begin
            if (pending[t]) begin
                pending[t] = 1'b0;
                killed[t] = 1'b1;
            end
        end
        outstanding = 0;
    endtask

    // Results shown in the kill cycle still count, the rest is dropped
    always @(posedge clk) begin
        if (rst_n) begin
            cycle++;
            if (credit_return) begin
                credits++;
            end
            check_eq("credit_count_range", int'(credits >= 0 && credits <= QUEUE_DEPTH), 1);
            if (int_wb.valid) begin
                take_writeback(int_wb, 1'b0);
            end
            if (lsu_wb.valid) begin
                take_writeback(lsu_wb, 1'b1);
            end
            if (kill) begin
                flush_outstanding();
            end
        end
    end

    // ================================================
    // Main sequence
    // ================================================

    initial begin
        int n;
        kill = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_instr = '0;
        credits = QUEUE_DEPTH;
        outstanding = 0;
        cycle = 0;
        checks = 0;
        errors = 0;
        timeouts = 0;
        for (int t = 0; t < 256; t++) begin
            pending[t] = 1'b0;
            killed[t] = 1'b0;
            wb_cycle[t] = -1;
        end
        for (int r = 0; r < 32; r++) begin
            last_writer[r] = -1;
        end
        build_rows();

        n = 0;
        while (!rst_n && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!rst_n) begin
            timeouts++;
            $display("Timed out waiting for reset release");
        end
        @(negedge clk);

        // Idle state right after reset
        check_eq("pipeline_empty_o", int'(pipeline_empty), 1);
        check_eq("credit_return_o", int'(credit_return), 0);
        check_eq("int_wb_o.valid", int'(int_wb.valid), 0);
        check_eq("lsu_wb_o.valid", int'(lsu_wb.valid), 0);

        for (int i = 0; i < rows.size() && timeouts == 0; i++) begin
            if (rows[i].kill) begin
                apply_kill();
            end
            if (timeouts == 0) begin
                wait_credit();
            end
            if (timeouts == 0) begin
                send_row(i);
            end
        end

        if (timeouts == 0) begin
            wait_idle("the final drain");
            check_eq("credits_at_end", credits, QUEUE_DEPTH);
            // Independent ALU overtakes the DIV ahead of it
            check_eq("alu_before_div",
                     int'(wb_cycle[alu_tag] >= 0 && wb_cycle[alu_tag] < wb_cycle[div_tag]), 1);
        end

        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
design/int_issue_pkg.sv
design/issue_queue.sv
design/int_scheduler.sv
design/int_exec_units.sv
design/lsu_model.sv
design/int_issue_top.sv
tests/tb_clock_gen.sv
tests/tb_int_issue.sv

// File: Makefile
# Verilator build and run of the integer issue stage testbench

VERILATOR ?= verilator
TOP       ?= tb_int_issue
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)
